/* include/muldiv_ref_model.svh */
// reference functions for the testbench
// signed product, quotient and remainder with the zero divisor rules
`ifndef MULDIV_REF_MODEL_SVH
`define MULDIV_REF_MODEL_SVH

// full signed 64-bit product
function automatic logic [63:0] ref_product(logic [31:0] a, logic [31:0] b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa = $signed({{32{a[31]}}, a});
  sb = $signed({{32{b[31]}}, b});
  return sa * sb;
endfunction

// remainder over quotient, magnitudes divided, signs applied afterwards
function automatic logic [63:0] ref_divide(muldiv_op_pkg::muldiv_op_e op,
                                           logic [31:0] a, logic [31:0] b);
  logic        a_neg;
  logic        b_neg;
  logic [31:0] ma;
  logic [31:0] mb;
  logic [31:0] q;
  logic [31:0] r;
  a_neg = (op == muldiv_op_pkg::op_div) && a[31];
  b_neg = (op == muldiv_op_pkg::op_div) && b[31];
  ma = a_neg ? -a : a;
  mb = b_neg ? -b : b;
  // zero divisor gives all ones and the dividend magnitude
  q = (mb == 32'd0) ? 32'hffff_ffff : ma / mb;
  r = (mb == 32'd0) ? ma : ma % mb;
  q = (a_neg ^ b_neg) ? -q : q;
  r = a_neg ? -r : r;
  return {r, q};
endfunction

// expected result for any opcode
function automatic logic [63:0] ref_result(muldiv_op_pkg::muldiv_op_e op,
                                           logic [31:0] a, logic [31:0] b);
  return (op == muldiv_op_pkg::op_mul) ? ref_product(a, b) : ref_divide(op, a, b);
endfunction

`endif

/* dv/tb_int_muldiv.sv */
// random-stimulus testbench for the multiply/divide subsystem
// per-unit result queues, timing and grant model, stall monitor and watchdog
`timescale 1ns/1ns

module tb_int_muldiv;

  import muldiv_op_pkg::*;
  import muldiv_seq_pkg::*;

  `include "muldiv_ref_model.svh"

  localparam int total_ops  = 400;
  localparam int clk_period = 8;
  // watchdog allowance per operation in cycles
  localparam int op_budget  = 80;
  // accept edge to the first edge that samples resp_val high
  localparam int resp_delay = 34;

  logic                 clk;
  logic                 reset;
  logic                 req_val;
  logic                 req_rdy;
  muldiv_op_e           req_op;
  logic [data_w-1:0]    req_a;
  logic [data_w-1:0]    req_b;
  logic                 resp_val;
  logic                 resp_rdy;
  muldiv_unit_e         resp_unit;
  logic [result_w-1:0]  resp_result;

  // ------------------------------------------------------------
  // model state
  // ------------------------------------------------------------

  logic [31:0]          rng_state = 32'hefc7;
  logic [result_w-1:0]  mul_q[$];
  logic [result_w-1:0]  div_q[$];
  logic [result_w-1:0]  exp_result;
  logic [result_w-1:0]  stall_result;
  bit                   busy_mul;
  bit                   busy_div;
  bit                   mul_ready;
  bit                   div_ready;
  bit                   q_empty;
  bit                   stalled;
  int unsigned          cyc;
  int unsigned          acc_mul;
  int unsigned          acc_div;
  muldiv_unit_e         rr_ptr;
  muldiv_unit_e         last_grant;
  muldiv_unit_e         exp_unit;
  muldiv_unit_e         req_unit;
  muldiv_unit_e         stall_unit;
  int                   accepted;
  int                   responded;
  int                   result_errors;
  int                   unit_errors;
  int                   flag_errors;
  int                   other_errors;

  int_muldiv uut (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_unit   (resp_unit),
    .resp_result (resp_result)
  );

  always #(clk_period / 2) clk = ~clk;

  // xorshift32 step on the shared state
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic muldiv_op_e pick_op();
    case (next_rand() % 3)
      0: return op_mul;
      1: return op_div;
      default: return op_divu;
    endcase
  endfunction

  // one draw in eight comes from the corner values
  function automatic logic [data_w-1:0] draw_operand();
    if (next_rand() % 8 == 0) begin
      case (next_rand() % 4)
        0: return 32'h0000_0000;
        1: return 32'hffff_ffff;
        2: return 32'h8000_0000;
        default: return 32'h0000_0001;
      endcase
    end
    return next_rand();
  endfunction

  task automatic check_result(string name, logic [result_w-1:0] expected,
                              logic [result_w-1:0] actual);
    if (actual !== expected) begin
      result_errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_unit(string name, muldiv_unit_e expected, muldiv_unit_e actual,
                            bit from_empty);
    if (from_empty) begin
      unit_errors++;
      $display("response from unit %0d arrived with no operation outstanding", actual);
    end
    if (actual !== expected) begin
      unit_errors++;
      $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // ------------------------------------------------------------
  // monitor and driver in one process per edge
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      // result ready once 33 edges have passed since the accept
      mul_ready = busy_mul && (cyc - acc_mul >= resp_delay);
      div_ready = busy_div && (cyc - acc_div >= resp_delay);
      // stalled source keeps the port and round-robin applies when both wait
      if (stalled) begin
        exp_unit = last_grant;
      end else if (mul_ready && div_ready) begin
        exp_unit = rr_ptr;
      end else if (div_ready) begin
        exp_unit = unit_div;
      end else begin
        exp_unit = unit_mul;
      end
      req_unit = (req_op == op_mul) ? unit_mul : unit_div;
      check_flag("req_rdy", (req_unit == unit_mul) ? !busy_mul : !busy_div, req_rdy);
      check_flag("resp_val", mul_ready || div_ready, resp_val);
      // a stalled response must not move
      if (stalled) begin
        check_unit("stalled unit", stall_unit, resp_unit, 1'b0);
        check_result("stalled result", stall_result, resp_result);
      end
      if (resp_val && resp_rdy) begin
        q_empty = (resp_unit == unit_mul) ? (mul_q.size() == 0) : (div_q.size() == 0);
        check_unit("response unit", exp_unit, resp_unit, q_empty);
        if (!q_empty) begin
          if (resp_unit == unit_mul) begin
            exp_result = mul_q.pop_front();
            busy_mul = 1'b0;
          end else begin
            exp_result = div_q.pop_front();
            busy_div = 1'b0;
          end
          check_result((resp_unit == unit_mul) ? "mul result" : "div result",
                       exp_result, resp_result);
        end
        responded++;
        rr_ptr = (exp_unit == unit_mul) ? unit_div : unit_mul;
      end else if (resp_val) begin
        check_unit("granted unit", exp_unit, resp_unit, 1'b0);
      end
      // accepted request goes into the queue of its unit
      if (req_val && req_rdy) begin
        exp_result = ref_result(req_op, req_a, req_b);
        if (req_unit == unit_mul) begin
          mul_q.push_back(exp_result);
          busy_mul = 1'b1;
          acc_mul = cyc;
        end else begin
          div_q.push_back(exp_result);
          busy_div = 1'b1;
          acc_div = cyc;
        end
        accepted++;
      end
      stalled = resp_val && !resp_rdy;
      stall_unit = resp_unit;
      stall_result = resp_result;
      last_grant = exp_unit;
      cyc++;
      // next inputs
      if (accepted == 0) begin
        // signed overflow corner goes first
        req_val <= 1'b1;
        req_op <= op_div;
        req_a <= 32'h8000_0000;
        req_b <= 32'hffff_ffff;
      end else begin
        if (accepted < total_ops) begin
          req_val <= (next_rand() % 4) != 0;
        end else begin
          req_val <= 1'b0;
        end
        req_op <= pick_op();
        req_a <= draw_operand();
        req_b <= draw_operand();
      end
      // about 70 percent ready
      resp_rdy <= (next_rand() % 10) < 7;
    end
  end

  // ------------------------------------------------------------
  // sequence and end of run
  // ------------------------------------------------------------

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    req_val = 1'b0;
    req_op = op_mul;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b0;
    busy_mul = 1'b0;
    busy_div = 1'b0;
    stalled = 1'b0;
    cyc = 0;
    rr_ptr = unit_mul;
    last_grant = unit_mul;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    // idle after reset with nothing sent yet
    check_flag("reset req_rdy", 1'b1, req_rdy);
    check_flag("reset resp_val", 1'b0, resp_val);
    wait (accepted >= total_ops && responded >= total_ops);
    @(negedge clk);
    if (mul_q.size() != 0 || div_q.size() != 0) begin
      other_errors++;
      $display("results left over at the end: %0d mul, %0d div", mul_q.size(), div_q.size());
    end
    $display("errors: result %0d, unit %0d, flag %0d, other %0d",
             result_errors, unit_errors, flag_errors, other_errors);
    if (result_errors + unit_errors + flag_errors + other_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(total_ops * op_budget * clk_period);
    $display("timeout: only %0d of %0d responses received", responded, total_ops);
    $display("Result: FAILED");
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
hdl/muldiv_op_pkg.sv
hdl/muldiv_seq_pkg.sv
hdl/int_div_iterative.sv
hdl/int_mul_iterative.sv
hdl/muldiv_port_arbiter.sv
hdl/int_muldiv.sv
dv/tb_int_muldiv.sv

/* hdl/int_div_iterative.sv */
// restoring integer divider, signed and unsigned
// one quotient bit per cycle, sign fixed up on the output
`timescale 1ns/1ns

module int_div_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  muldiv_op_pkg::muldiv_op_e           req_op,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_a,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output logic [muldiv_op_pkg::result_w-1:0]  resp_result
);

  import muldiv_op_pkg::*;
  import muldiv_seq_pkg::*;

  iter_state_e          state;
  logic [count_w-1:0]   count;
  logic                 req_go;
  logic                 resp_go;
  logic                 last_iter;
  logic                 is_signed;
  logic [data_w-1:0]    a_mag;
  logic [data_w-1:0]    b_mag;
  logic                 a_neg;
  logic                 b_neg;
  // remainder in the upper bits, quotient in the lower word
  logic [result_w:0]    rq_reg;
  logic [result_w:0]    dvsr_reg;
  logic [result_w:0]    rq_shift;
  logic [result_w:0]    rq_diff;
  logic [result_w:0]    rq_next;
  logic [data_w-1:0]    quo_mag;
  logic [data_w-1:0]    rem_mag;
  logic [data_w-1:0]    quo;
  logic [data_w-1:0]    rem;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  // count reaches iter_count one edge after the last iteration
  assign last_iter = (count == count_w'(iter_count));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_iter) begin
            state <= st_done;
          end else begin
            count <= count + count_w'(1);
          end
        end
        st_done: begin
          // stay here under back-pressure
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  // signs only matter for the signed opcode
  assign is_signed = (req_op == op_div);
  assign a_mag     = (is_signed && req_a[data_w-1]) ? -req_a : req_a;
  assign b_mag     = (is_signed && req_b[data_w-1]) ? -req_b : req_b;

  // shift, then trial subtract
  assign rq_shift = rq_reg << 1;
  assign rq_diff  = rq_shift - dvsr_reg;
  // negative difference means restore and shift in a zero
  assign rq_next  = rq_diff[result_w] ? {rq_shift[result_w:1], 1'b0}
                                      : {rq_diff[result_w:1], 1'b1};

  always_ff @(posedge clk) begin
    if (req_go) begin
      a_neg    <= is_signed && req_a[data_w-1];
      b_neg    <= is_signed && req_b[data_w-1];
      rq_reg   <= {{(data_w + 1){1'b0}}, a_mag};
      dvsr_reg <= {1'b0, b_mag, {data_w{1'b0}}};
    end else if ((state == st_calc) && !last_iter) begin
      rq_reg <= rq_next;
    end
  end

  // zero divisor never fails the subtraction
  // so the quotient comes out all ones and the remainder is |a|
  assign quo_mag = rq_reg[data_w-1:0];
  assign rem_mag = rq_reg[result_w-1:data_w];

  // sign fix-up, no extra cycle
  assign quo = (a_neg ^ b_neg) ? -quo_mag : quo_mag;
  assign rem = a_neg ? -rem_mag : rem_mag;

  assign resp_result = {rem, quo};

endmodule

/* hdl/int_mul_iterative.sv */
// signed shift-add multiplier, one multiplier bit per cycle
// works on magnitudes and negates the product at the end
`timescale 1ns/1ns

module int_mul_iterative (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_a,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output logic [muldiv_op_pkg::result_w-1:0]  resp_result
);

  import muldiv_op_pkg::*;
  import muldiv_seq_pkg::*;

  iter_state_e          state;
  logic [count_w-1:0]   count;
  logic                 req_go;
  logic                 resp_go;
  logic                 last_iter;
  logic [data_w-1:0]    a_mag;
  logic [data_w-1:0]    b_mag;
  logic                 neg_reg;
  logic [result_w-1:0]  mcand_reg;
  logic [data_w-1:0]    mplier_reg;
  logic [result_w-1:0]  acc_reg;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  assign req_rdy   = (state == st_idle);
  assign resp_val  = (state == st_done);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign last_iter = (count == count_w'(iter_count));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
            count <= '0;
          end
        end
        st_calc: begin
          if (last_iter) begin
            state <= st_done;
          end else begin
            count <= count + count_w'(1);
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  // most negative value maps onto itself, still correct as unsigned
  assign a_mag = req_a[data_w-1] ? -req_a : req_a;
  assign b_mag = req_b[data_w-1] ? -req_b : req_b;

  always_ff @(posedge clk) begin
    if (req_go) begin
      neg_reg    <= req_a[data_w-1] ^ req_b[data_w-1];
      mcand_reg  <= {{data_w{1'b0}}, a_mag};
      mplier_reg <= b_mag;
      acc_reg    <= '0;
    end else if ((state == st_calc) && !last_iter) begin
      // add when the current multiplier bit is set
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg  <= mcand_reg << 1;
      mplier_reg <= mplier_reg >> 1;
    end
  end

  assign resp_result = neg_reg ? -acc_reg : acc_reg;

endmodule

/* hdl/int_muldiv.sv */
// multiply/divide subsystem top level
// two iterative units behind one request and one response port
`timescale 1ns/1ns

module int_muldiv (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  output logic                                req_rdy,
  input  muldiv_op_pkg::muldiv_op_e           req_op,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_a,
  input  logic [muldiv_op_pkg::data_w-1:0]    req_b,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output muldiv_seq_pkg::muldiv_unit_e        resp_unit,
  output logic [muldiv_op_pkg::result_w-1:0]  resp_result
);

  import muldiv_op_pkg::*;

  // multiplier side
  logic                 mul_req_val;
  logic                 mul_req_rdy;
  logic                 mul_resp_val;
  logic                 mul_resp_rdy;
  logic [result_w-1:0]  mul_result;
  // divider side
  logic                 div_req_val;
  logic                 div_req_rdy;
  logic                 div_resp_val;
  logic                 div_resp_rdy;
  logic [result_w-1:0]  div_result;

  // operands go to both units, only the selected one sees req_val
  int_mul_iterative u_mul (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_result)
  );

  int_div_iterative u_div (
    .clk         (clk),
    .reset       (reset),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_result)
  );

  muldiv_port_arbiter u_arb (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_op       (req_op),
    .req_rdy      (req_rdy),
    .mul_req_val  (mul_req_val),
    .div_req_val  (div_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .div_req_rdy  (div_req_rdy),
    .mul_resp_val (mul_resp_val),
    .div_resp_val (div_resp_val),
    .mul_result   (mul_result),
    .div_result   (div_result),
    .mul_resp_rdy (mul_resp_rdy),
    .div_resp_rdy (div_resp_rdy),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .resp_unit    (resp_unit),
    .resp_result  (resp_result)
  );

endmodule

/* hdl/muldiv_op_pkg.sv */
// operation encoding and data widths for the multiply/divide subsystem
// shared by both units, the arbiter and the top level

package muldiv_op_pkg;

  // ------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------

  // operand width, both units
  localparam int data_w = 32;

  // full result width
  // product for multiply, remainder over quotient for divide
  localparam int result_w = 64;

  // ------------------------------------------------------------
  // opcodes
  // ------------------------------------------------------------

  // op_mul   signed 32x32 multiply, full 64-bit product
  // op_div   signed divide, remainder takes the dividend's sign
  // op_divu  unsigned divide
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } muldiv_op_e;

  // code 2'd3 is unused
  // the arbiter routes it to the divider like any non-multiply op
  // the divider then treats it as unsigned

endpackage

/* hdl/muldiv_port_arbiter.sv */
// request steering by opcode and round-robin grant of the response port
// the grant is held while a response is stalled
`timescale 1ns/1ns

module muldiv_port_arbiter (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  input  muldiv_op_pkg::muldiv_op_e           req_op,
  output logic                                req_rdy,
  output logic                                mul_req_val,
  output logic                                div_req_val,
  input  logic                                mul_req_rdy,
  input  logic                                div_req_rdy,
  input  logic                                mul_resp_val,
  input  logic                                div_resp_val,
  input  logic [muldiv_op_pkg::result_w-1:0]  mul_result,
  input  logic [muldiv_op_pkg::result_w-1:0]  div_result,
  output logic                                mul_resp_rdy,
  output logic                                div_resp_rdy,
  output logic                                resp_val,
  input  logic                                resp_rdy,
  output muldiv_seq_pkg::muldiv_unit_e        resp_unit,
  output logic [muldiv_op_pkg::result_w-1:0]  resp_result
);

  import muldiv_op_pkg::*;
  import muldiv_seq_pkg::*;

  muldiv_unit_e  req_unit;
  muldiv_unit_e  ptr;
  muldiv_unit_e  grant;
  muldiv_unit_e  hold_unit;
  logic          hold;
  logic          resp_go;

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  // everything that is not a multiply goes to the divider
  assign req_unit    = (req_op == op_mul) ? unit_mul : unit_div;
  assign mul_req_val = req_val && (req_unit == unit_mul);
  assign div_req_val = req_val && (req_unit == unit_div);
  // ready follows the opcode only, never req_val
  assign req_rdy     = (req_unit == unit_mul) ? mul_req_rdy : div_req_rdy;

  // ------------------------------------------------------------
  // response side
  // ------------------------------------------------------------

  always_comb begin
    if (hold) begin
      // keep the stalled source on the port
      grant = hold_unit;
    end else if (mul_resp_val && div_resp_val) begin
      grant = ptr;
    end else if (div_resp_val) begin
      grant = unit_div;
    end else begin
      grant = unit_mul;
    end
  end

  assign resp_val     = mul_resp_val || div_resp_val;
  assign resp_go      = resp_val && resp_rdy;
  assign resp_unit    = grant;
  assign resp_result  = (grant == unit_mul) ? mul_result : div_result;
  assign mul_resp_rdy = resp_rdy && (grant == unit_mul);
  assign div_resp_rdy = resp_rdy && (grant == unit_div);

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr       <= unit_mul;
      hold      <= 1'b0;
      hold_unit <= unit_mul;
    end else begin
      hold      <= resp_val && !resp_rdy;
      hold_unit <= grant;
      // pointer moves away from the unit just served
      if (resp_go) begin
        ptr <= (grant == unit_mul) ? unit_div : unit_mul;
      end
    end
  end

endmodule

/* hdl/muldiv_seq_pkg.sv */
// iteration FSM states, iteration count and unit identifiers
// used by both iterative units and by the response arbiter

package muldiv_seq_pkg;

  // unit FSM states
  // st_done holds the result until the response handshake
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_e;

  // one result bit per iteration
  localparam int iter_count = 32;

  // counter must be able to hold iter_count itself
  localparam int count_w = 6;

  // unit names, for the grant pointer and the response port
  typedef enum logic {
    unit_mul = 1'b0,
    unit_div = 1'b1
  } muldiv_unit_e;

endpackage
